// File: sim.f
+incdir+tb
design/periph_pkg.sv
design/periph_decoder.sv
design/periph_timer.sv
design/periph_plic.sv
design/periph_top.sv
tb/tb_periph.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_periph
./obj_dir/Vtb_periph

// File: tb/tb_periph_tasks.svh
// ------------------------------------------------------------------------
// Failure and checks
// ------------------------------------------------------------------------
task automatic end_with_failure();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on a failed check");
endtask

task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end_with_failure();
    end
endtask

// Slot in bits 15:12, word offset in bits 5:2
function automatic logic [periph_pkg::ADDR_W-1:0] reg_addr(input int slot, input int offs);
    logic [periph_pkg::ADDR_W-1:0] addr;
    addr = '0;
    addr[periph_pkg::SLOT_LSB +: periph_pkg::SLOT_W] = slot[periph_pkg::SLOT_W-1:0];
    addr[periph_pkg::OFFS_LSB +: periph_pkg::OFFS_W] = offs[periph_pkg::OFFS_W-1:0];
    return addr;
endfunction

function automatic logic [periph_pkg::ADDR_W-1:0] timer_reg(input int offs);
    return reg_addr(int'(periph_pkg::SLOT_TIMER), offs);
endfunction

function automatic logic [periph_pkg::ADDR_W-1:0] plic_reg(input int offs);
    return reg_addr(int'(periph_pkg::SLOT_PLIC), offs);
endfunction

// ------------------------------------------------------------------------
// Bus access
// ------------------------------------------------------------------------
// Entered 2 ns after a rising edge, and left at the same point
task automatic bus_access(input logic write, input logic [periph_pkg::ADDR_W-1:0] addr,
                          input logic [31:0] wdata, input int stall,
                          output logic [31:0] rdata, output logic err);
    int waited;
    req_valid_i = 1'b1;
    req_write_i = write;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    waited = 0;
    while (!req_ready_o) begin
        @(posedge clk_i);
        #2;
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
            $display("Timeout: the request to address %h was never accepted", addr);
            end_with_failure();
        end
    end
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    waited = 0;
    while (!rsp_valid_o) begin
        @(posedge clk_i);
        #2;
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
            $display("Timeout: no response came for the request to address %h", addr);
            end_with_failure();
        end
    end
    rdata = rsp_rdata_o;
    err   = rsp_error_o;
    // Response must hold while rsp_ready_i is low
    for (int i = 0; i < stall; i++) begin
        check("stalled rsp_valid_o", 32'(rsp_valid_o), 32'd1);
        check("stalled rsp_rdata_o", rsp_rdata_o, rdata);
        check("stalled rsp_error_o", 32'(rsp_error_o), 32'(err));
        check("req_ready_o during stall", 32'(req_ready_o), 32'd0);
        @(posedge clk_i);
        #2;
    end
    rsp_ready_i = 1'b1;
    @(posedge clk_i);
    #2;
    rsp_ready_i = 1'b0;
endtask

task automatic bus_write(input logic [periph_pkg::ADDR_W-1:0] addr, input logic [31:0] wdata,
                         input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, addr, wdata, 0, rdata, err);
    check($sformatf("write error flag at %h", addr), 32'(err), 32'(exp_err));
    check($sformatf("write response data at %h", addr), rdata, 32'd0);
endtask

task automatic bus_read(input logic [periph_pkg::ADDR_W-1:0] addr, input logic exp_err,
                        output logic [31:0] rdata);
    logic err;
    bus_access(1'b0, addr, 32'd0, 0, rdata, err);
    check($sformatf("read error flag at %h", addr), 32'(err), 32'(exp_err));
endtask

task automatic read_expect(input logic [periph_pkg::ADDR_W-1:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    bus_read(addr, 1'b0, rdata);
    check($sformatf("read data at %h", addr), rdata, exp);
endtask

task automatic wait_irq(input logic level, input string cause);
    int waited;
    waited = 0;
    while (irq_o !== level) begin
        @(posedge clk_i);
        #2;
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
            $display("Timeout: irq_o never went to %0b after %s", level, cause);
            end_with_failure();
        end
    end
endtask

// File: tb/tb_periph.sv
`timescale 1ns/1ps

module tb_periph;

    localparam int TIMEOUT_CYCLES = 200;

    logic                           clk_i;
    logic                           arst_n_i;
    logic                           req_valid_i;
    logic                           req_ready_o;
    logic                           req_write_i;
    logic [periph_pkg::ADDR_W-1:0]  req_addr_i;
    logic [periph_pkg::DATA_W-1:0]  req_wdata_i;
    logic                           rsp_valid_o;
    logic                           rsp_ready_i;
    logic [periph_pkg::DATA_W-1:0]  rsp_rdata_o;
    logic                           rsp_error_o;
    logic [1:0]                     irq_ext_i;
    logic                           irq_o;

    periph_top dut0 (.*);

    // 40 ns period
    always #20 clk_i = ~clk_i;

    `include "tb_periph_tasks.svh"

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic register_readback();
        logic [31:0] val;
        logic [31:0] prio_mask;
        prio_mask = (32'd1 << periph_pkg::PRIO_W) - 32'd1;
        for (int t = 0; t < periph_pkg::NUM_TIMERS; t++) begin
            val = $urandom();
            bus_write(timer_reg(int'(periph_pkg::T0_COMPARE) + 4 * t), val, 1'b0);
            read_expect(timer_reg(int'(periph_pkg::T0_COMPARE) + 4 * t), val);
        end
        // PRIO1 to PRIO4 and THRESHOLD, ENABLE skipped
        for (int r = 0; r <= int'(periph_pkg::PLIC_THRESHOLD); r++) begin
            if (r != int'(periph_pkg::PLIC_ENABLE)) begin
                val = $urandom();
                bus_write(plic_reg(r), val, 1'b0);
                read_expect(plic_reg(r), val & prio_mask);
            end
        end
    endtask

    task automatic error_responses();
        logic [31:0] rd;
        logic [31:0] compare0;
        logic [31:0] prio3;
        compare0 = $urandom();
        // Low bits differ from those of ~compare0
        prio3    = compare0 & ((32'd1 << periph_pkg::PRIO_W) - 32'd1);
        bus_write(timer_reg(int'(periph_pkg::T0_COMPARE)), compare0, 1'b0);
        bus_write(plic_reg(int'(periph_pkg::PLIC_PRIO3)), prio3, 1'b0);
        for (int s = 2; s < (1 << periph_pkg::SLOT_W); s++) begin
            bus_read(reg_addr(s, s % 8), 1'b1, rd);
            check("unmapped slot read data", rd, 32'hDEADBEEF);
            // Offset 2 is live in both mapped slots
            bus_write(reg_addr(s, 2), ~compare0, 1'b1);
        end
        read_expect(timer_reg(int'(periph_pkg::T0_COMPARE)), compare0);
        read_expect(plic_reg(int'(periph_pkg::PLIC_PRIO3)), prio3);
        for (int o = 8; o < 16; o++) begin
            bus_read(timer_reg(o), 1'b1, rd);
            bus_write(timer_reg(o), 32'hFFFF_FFFF, 1'b1);
        end
        for (int o = 7; o < 16; o++) begin
            bus_read(plic_reg(o), 1'b1, rd);
            bus_write(plic_reg(o), 32'hFFFF_FFFF, 1'b1);
        end
    endtask

    task automatic back_pressure();
        logic [periph_pkg::ADDR_W-1:0] addrs [3];
        logic [31:0]                   vals  [3];
        logic [31:0]                   rd;
        logic                          err;
        addrs[0] = timer_reg(int'(periph_pkg::T0_COMPARE));
        addrs[1] = timer_reg(int'(periph_pkg::T1_COMPARE));
        // Timer 1 stays disabled so its COUNT holds
        addrs[2] = timer_reg(int'(periph_pkg::T1_COUNT));
        for (int i = 0; i < 3; i++) begin
            vals[i] = $urandom();
            bus_access(1'b1, addrs[i], vals[i], i + 2, rd, err);
            check("stalled write error flag", 32'(err), 32'd0);
        end
        for (int n = 0; n < 6; n++) begin
            bus_access(1'b0, addrs[n % 3], 32'd0, 3 + n, rd, err);
            check("stalled read data", rd, vals[n % 3]);
            check("stalled read error flag", 32'(err), 32'd0);
        end
    endtask

    task automatic priority_arbitration();
        logic [periph_pkg::ADDR_W-1:0] claim;
        logic [periph_pkg::ADDR_W-1:0] threshold;
        claim     = plic_reg(int'(periph_pkg::PLIC_CLAIM));
        threshold = plic_reg(int'(periph_pkg::PLIC_THRESHOLD));
        bus_write(plic_reg(int'(periph_pkg::PLIC_PRIO1)), 32'd2, 1'b0);
        bus_write(plic_reg(int'(periph_pkg::PLIC_PRIO2)), 32'd5, 1'b0);
        bus_write(threshold, 32'd0, 1'b0);
        bus_write(plic_reg(int'(periph_pkg::PLIC_ENABLE)), 32'h3, 1'b0);
        irq_ext_i = 2'b11;
        wait_irq(1'b1, "raising both external inputs");
        read_expect(claim, periph_pkg::SRC_EXT1);
        irq_ext_i[1] = 1'b0;
        bus_write(claim, periph_pkg::SRC_EXT1, 1'b0);
        read_expect(claim, periph_pkg::SRC_EXT0);
        check("irq_o with ext0 in service", 32'(irq_o), 32'd0);
        // Priority 5 is not above a threshold of 5
        bus_write(threshold, 32'd5, 1'b0);
        bus_write(claim, periph_pkg::SRC_EXT0, 1'b0);
        irq_ext_i[1] = 1'b1;
        read_expect(threshold, 32'd5);
        read_expect(claim, 32'd0);
        check("irq_o under threshold 5", 32'(irq_o), 32'd0);
        bus_write(threshold, 32'd4, 1'b0);
        wait_irq(1'b1, "lowering the threshold to 4");
        read_expect(claim, periph_pkg::SRC_EXT1);
        irq_ext_i = 2'b00;
        bus_write(claim, periph_pkg::SRC_EXT1, 1'b0);
        bus_write(threshold, 32'd0, 1'b0);
        wait_irq(1'b0, "lowering and completing all sources");
        read_expect(claim, 32'd0);
    endtask

    task automatic timer_interrupt();
        logic [31:0] count;
        logic [31:0] prev;
        logic        wrapped;
        bus_write(plic_reg(int'(periph_pkg::PLIC_PRIO3)), 32'd6, 1'b0);
        bus_write(plic_reg(int'(periph_pkg::PLIC_ENABLE)), 32'h4, 1'b0);
        bus_write(timer_reg(int'(periph_pkg::T0_COMPARE)), 32'd50, 1'b0);
        bus_write(timer_reg(int'(periph_pkg::T0_COUNT)), 32'd0, 1'b0);
        bus_write(timer_reg(int'(periph_pkg::T0_CTRL)), 32'd1, 1'b0);
        wait_irq(1'b1, "enabling timer 0");
        read_expect(plic_reg(int'(periph_pkg::PLIC_CLAIM)), periph_pkg::SRC_TIMER0);
        read_expect(timer_reg(int'(periph_pkg::T0_STATUS)), 32'd1);
        bus_write(timer_reg(int'(periph_pkg::T0_STATUS)), 32'd1, 1'b0);
        read_expect(timer_reg(int'(periph_pkg::T0_STATUS)), 32'd0);
        bus_write(plic_reg(int'(periph_pkg::PLIC_CLAIM)), periph_pkg::SRC_TIMER0, 1'b0);
        wait_irq(1'b0, "clearing and completing timer 0");
        // Counter wraps at COMPARE, reads span more than two periods
        prev    = 32'd0;
        wrapped = 1'b0;
        for (int n = 0; n < 60; n++) begin
            bus_read(timer_reg(int'(periph_pkg::T0_COUNT)), 1'b0, count);
            check("COUNT not above COMPARE", 32'(count <= 32'd50), 32'd1);
            if (count < prev) begin
                wrapped = 1'b1;
            end
            prev = count;
        end
        check("COUNT wrapped during the reads", 32'(wrapped), 32'd1);
        bus_write(timer_reg(int'(periph_pkg::T0_CTRL)), 32'd0, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------------------
    initial begin
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b0;
        irq_ext_i   = 2'b00;
        void'($urandom(27409));
        repeat (10) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        check("req_ready_o after reset", 32'(req_ready_o), 32'd1);
        check("rsp_valid_o after reset", 32'(rsp_valid_o), 32'd0);
        check("irq_o after reset", 32'(irq_o), 32'd0);
        read_expect(timer_reg(int'(periph_pkg::T0_CTRL)), 32'd0);
        read_expect(timer_reg(int'(periph_pkg::T0_COUNT)), 32'd0);
        read_expect(timer_reg(int'(periph_pkg::T1_STATUS)), 32'd0);
        read_expect(plic_reg(int'(periph_pkg::PLIC_ENABLE)), 32'd0);
        read_expect(plic_reg(int'(periph_pkg::PLIC_THRESHOLD)), 32'd0);
        register_readback();
        error_responses();
        back_pressure();
        priority_arbitration();
        timer_interrupt();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: design/periph_top.sv
`timescale 1ns/1ps

module periph_top (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Request channel
    input  logic                            req_valid_i,
    output logic                            req_ready_o,
    input  logic                            req_write_i,
    input  logic [periph_pkg::ADDR_W-1:0]   req_addr_i,
    input  logic [periph_pkg::DATA_W-1:0]   req_wdata_i,
    // Response channel
    output logic                            rsp_valid_o,
    input  logic                            rsp_ready_i,
    output logic [periph_pkg::DATA_W-1:0]   rsp_rdata_o,
    output logic                            rsp_error_o,
    // Interrupts
    input  logic [1:0]                      irq_ext_i,
    output logic                            irq_o
);

    logic                                 plic_sel;
    logic                                 timer_sel;
    logic                                 bus_write;
    logic [periph_pkg::OFFS_W-1:0]        bus_offs;
    logic [periph_pkg::DATA_W-1:0]        bus_wdata;
    logic [periph_pkg::DATA_W-1:0]        plic_rdata;
    logic                                 plic_error;
    logic [periph_pkg::DATA_W-1:0]        timer_rdata;
    logic                                 timer_error;
    logic [periph_pkg::NUM_TIMERS-1:0]    timer_irq;
    logic [periph_pkg::NUM_SOURCES-1:0]   irq_src;

    // Source n sits at bit n-1
    assign irq_src[periph_pkg::SRC_EXT0-1]   = irq_ext_i[0];
    assign irq_src[periph_pkg::SRC_EXT1-1]   = irq_ext_i[1];
    assign irq_src[periph_pkg::SRC_TIMER0-1] = timer_irq[0];
    assign irq_src[periph_pkg::SRC_TIMER1-1] = timer_irq[1];

    periph_decoder i_decoder (
        .clk_i         ( clk_i       ),
        .arst_n_i      ( arst_n_i    ),
        .req_valid_i   ( req_valid_i ),
        .req_ready_o   ( req_ready_o ),
        .req_write_i   ( req_write_i ),
        .req_addr_i    ( req_addr_i  ),
        .req_wdata_i   ( req_wdata_i ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rsp_ready_i   ( rsp_ready_i ),
        .rsp_rdata_o   ( rsp_rdata_o ),
        .rsp_error_o   ( rsp_error_o ),
        .plic_sel_o    ( plic_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .bus_write_o   ( bus_write   ),
        .bus_offs_o    ( bus_offs    ),
        .bus_wdata_o   ( bus_wdata   ),
        .plic_rdata_i  ( plic_rdata  ),
        .plic_error_i  ( plic_error  ),
        .timer_rdata_i ( timer_rdata ),
        .timer_error_i ( timer_error )
    );

    periph_timer i_timer (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .sel_i       ( timer_sel   ),
        .write_i     ( bus_write   ),
        .offs_i      ( bus_offs    ),
        .wdata_i     ( bus_wdata   ),
        .rdata_o     ( timer_rdata ),
        .error_o     ( timer_error ),
        .timer_irq_o ( timer_irq   )
    );

    periph_plic i_plic (
        .clk_i    ( clk_i      ),
        .arst_n_i ( arst_n_i   ),
        .sel_i    ( plic_sel   ),
        .write_i  ( bus_write  ),
        .offs_i   ( bus_offs   ),
        .wdata_i  ( bus_wdata  ),
        .rdata_o  ( plic_rdata ),
        .error_o  ( plic_error ),
        .src_i    ( irq_src    ),
        .irq_o    ( irq_o      )
    );

endmodule

// File: design/periph_plic.sv
`timescale 1ns/1ps

module periph_plic (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                sel_i,
    input  logic                                write_i,
    input  logic [periph_pkg::OFFS_W-1:0]       offs_i,
    input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
    output logic [periph_pkg::DATA_W-1:0]       rdata_o,
    output logic                                error_o,
    input  logic [periph_pkg::NUM_SOURCES-1:0]  src_i,
    output logic                                irq_o
);

    logic [periph_pkg::PRIO_W-1:0]              prio_q [periph_pkg::NUM_SOURCES];
    logic [periph_pkg::NUM_SOURCES-1:0]         enable_q;
    logic [periph_pkg::PRIO_W-1:0]              threshold_q;
    logic [periph_pkg::NUM_SOURCES-1:0]         pending_q;
    logic [periph_pkg::NUM_SOURCES-1:0]         in_service_q;

    logic [$clog2(periph_pkg::NUM_SOURCES)-1:0] prio_idx;
    logic                                       wr_prio;
    logic                                       wr_enable;
    logic                                       wr_threshold;
    logic                                       claim_rd;
    logic                                       complete_wr;
    logic [periph_pkg::NUM_SOURCES-1:0]         claim_hit;
    logic [periph_pkg::NUM_SOURCES-1:0]         complete_mask;
    periph_pkg::id_t                            best_id;
    logic [periph_pkg::PRIO_W-1:0]              best_prio;

    assign prio_idx = offs_i[$clog2(periph_pkg::NUM_SOURCES)-1:0];
    assign irq_o    = (best_id != '0);

    // ------------------------------------------------------------------------
    // Arbiter
    // ------------------------------------------------------------------------
    always_comb begin
        best_id   = '0;
        best_prio = threshold_q;
        // Strict compare keeps ties on the lowest id and masks priority 0
        for (int i = 0; i < periph_pkg::NUM_SOURCES; i++) begin
            if (pending_q[i] && enable_q[i] && prio_q[i] > best_prio) begin
                best_id   = periph_pkg::id_t'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < periph_pkg::NUM_SOURCES; i++) begin
            claim_hit[i]     = claim_rd && (best_id == periph_pkg::id_t'(i + 1));
            complete_mask[i] = complete_wr &&
                               (wdata_i[periph_pkg::ID_W-1:0] == periph_pkg::id_t'(i + 1));
        end
    end

    // ------------------------------------------------------------------------
    // Register decode
    // ------------------------------------------------------------------------
    always_comb begin
        rdata_o      = '0;
        error_o      = 1'b0;
        wr_prio      = 1'b0;
        wr_enable    = 1'b0;
        wr_threshold = 1'b0;
        claim_rd     = 1'b0;
        complete_wr  = 1'b0;
        case (periph_pkg::plic_reg_e'(offs_i))
            periph_pkg::PLIC_PRIO1, periph_pkg::PLIC_PRIO2,
            periph_pkg::PLIC_PRIO3, periph_pkg::PLIC_PRIO4: begin
                rdata_o[periph_pkg::PRIO_W-1:0] = prio_q[prio_idx];
                wr_prio = sel_i && write_i;
            end
            periph_pkg::PLIC_ENABLE: begin
                rdata_o[periph_pkg::NUM_SOURCES-1:0] = enable_q;
                wr_enable = sel_i && write_i;
            end
            periph_pkg::PLIC_THRESHOLD: begin
                rdata_o[periph_pkg::PRIO_W-1:0] = threshold_q;
                wr_threshold = sel_i && write_i;
            end
            periph_pkg::PLIC_CLAIM: begin
                rdata_o[periph_pkg::ID_W-1:0] = best_id;
                claim_rd    = sel_i && !write_i;
                complete_wr = sel_i && write_i;
            end
            default: error_o = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q    <= '0;
            threshold_q <= '0;
            for (int i = 0; i < periph_pkg::NUM_SOURCES; i++) begin
                prio_q[i] <= '0;
            end
        end else begin
            if (wr_prio) begin
                prio_q[prio_idx] <= wdata_i[periph_pkg::PRIO_W-1:0];
            end
            if (wr_enable) begin
                enable_q <= wdata_i[periph_pkg::NUM_SOURCES-1:0];
            end
            if (wr_threshold) begin
                threshold_q <= wdata_i[periph_pkg::PRIO_W-1:0];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Level gateways
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            pending_q    <= src_i & ~in_service_q & ~claim_hit;
            in_service_q <= (in_service_q | claim_hit) & ~complete_mask;
        end
    end

endmodule

// File: design/periph_timer.sv
`timescale 1ns/1ps

module periph_timer (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                sel_i,
    input  logic                                write_i,
    input  logic [periph_pkg::OFFS_W-1:0]       offs_i,
    input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
    output logic [periph_pkg::DATA_W-1:0]       rdata_o,
    output logic                                error_o,
    output logic [periph_pkg::NUM_TIMERS-1:0]   timer_irq_o
);

    logic [periph_pkg::NUM_TIMERS-1:0]  enable_q;
    logic [periph_pkg::NUM_TIMERS-1:0]  flag_q;
    logic [periph_pkg::DATA_W-1:0]      count_q   [periph_pkg::NUM_TIMERS];
    logic [periph_pkg::DATA_W-1:0]      compare_q [periph_pkg::NUM_TIMERS];

    logic                               tmr_idx;
    logic                               do_write;
    logic                               wr_ctrl;
    logic                               wr_count;
    logic                               wr_compare;
    logic                               wr_status;

    // Four registers per timer
    assign tmr_idx  = offs_i[2];
    assign do_write = sel_i && write_i;

    assign timer_irq_o = flag_q;

    // ------------------------------------------------------------------------
    // Register decode
    // ------------------------------------------------------------------------
    always_comb begin
        rdata_o    = '0;
        error_o    = 1'b0;
        wr_ctrl    = 1'b0;
        wr_count   = 1'b0;
        wr_compare = 1'b0;
        wr_status  = 1'b0;
        case (periph_pkg::timer_reg_e'(offs_i))
            periph_pkg::T0_CTRL, periph_pkg::T1_CTRL: begin
                rdata_o[0] = enable_q[tmr_idx];
                wr_ctrl    = do_write;
            end
            periph_pkg::T0_COUNT, periph_pkg::T1_COUNT: begin
                rdata_o  = count_q[tmr_idx];
                wr_count = do_write;
            end
            periph_pkg::T0_COMPARE, periph_pkg::T1_COMPARE: begin
                rdata_o    = compare_q[tmr_idx];
                wr_compare = do_write;
            end
            periph_pkg::T0_STATUS, periph_pkg::T1_STATUS: begin
                rdata_o[0] = flag_q[tmr_idx];
                wr_status  = do_write;
            end
            default: error_o = 1'b1;
        endcase
    end

    // ------------------------------------------------------------------------
    // Counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q <= '0;
            flag_q   <= '0;
            for (int t = 0; t < periph_pkg::NUM_TIMERS; t++) begin
                count_q[t]   <= '0;
                compare_q[t] <= '0;
            end
        end else begin
            for (int t = 0; t < periph_pkg::NUM_TIMERS; t++) begin
                // Write-one-to-clear first so a match on the same edge wins
                if (wr_status && int'(tmr_idx) == t && wdata_i[0]) begin
                    flag_q[t] <= 1'b0;
                end
                if (enable_q[t]) begin
                    if (count_q[t] == compare_q[t]) begin
                        count_q[t] <= '0;
                        flag_q[t]  <= 1'b1;
                    end else begin
                        count_q[t] <= count_q[t] + 1'b1;
                    end
                end
                if (wr_count && int'(tmr_idx) == t) begin
                    count_q[t] <= wdata_i;
                end
                if (wr_compare && int'(tmr_idx) == t) begin
                    compare_q[t] <= wdata_i;
                end
                if (wr_ctrl && int'(tmr_idx) == t) begin
                    enable_q[t] <= wdata_i[0];
                end
            end
        end
    end

endmodule

// File: design/periph_decoder.sv
`timescale 1ns/1ps

module periph_decoder (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            req_valid_i,
    output logic                            req_ready_o,
    input  logic                            req_write_i,
    input  logic [periph_pkg::ADDR_W-1:0]   req_addr_i,
    input  logic [periph_pkg::DATA_W-1:0]   req_wdata_i,
    output logic                            rsp_valid_o,
    input  logic                            rsp_ready_i,
    output logic [periph_pkg::DATA_W-1:0]   rsp_rdata_o,
    output logic                            rsp_error_o,
    output logic                            plic_sel_o,
    output logic                            timer_sel_o,
    output logic                            bus_write_o,
    output logic [periph_pkg::OFFS_W-1:0]   bus_offs_o,
    output logic [periph_pkg::DATA_W-1:0]   bus_wdata_o,
    input  logic [periph_pkg::DATA_W-1:0]   plic_rdata_i,
    input  logic                            plic_error_i,
    input  logic [periph_pkg::DATA_W-1:0]   timer_rdata_i,
    input  logic                            timer_error_i
);

    typedef enum logic {
        IDLE,
        RESP
    } state_e;

    state_e                           state_q;
    logic                             accept;
    logic [periph_pkg::SLOT_W-1:0]    slot;
    logic [periph_pkg::DATA_W-1:0]    rdata_d;
    logic                             error_d;

    assign req_ready_o = (state_q == IDLE);
    assign rsp_valid_o = (state_q == RESP);
    assign accept      = req_valid_i && req_ready_o;

    assign slot        = req_addr_i[periph_pkg::ADDR_W-1:periph_pkg::SLOT_LSB];
    assign bus_offs_o  = req_addr_i[periph_pkg::OFFS_LSB +: periph_pkg::OFFS_W];
    assign bus_write_o = req_write_i;
    assign bus_wdata_o = req_wdata_i;

    // Select strobes last only for the accept cycle
    assign plic_sel_o  = accept && (slot == periph_pkg::SLOT_PLIC);
    assign timer_sel_o = accept && (slot == periph_pkg::SLOT_TIMER);

    // ------------------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------------------
    always_comb begin
        case (slot)
            periph_pkg::SLOT_PLIC: begin
                rdata_d = plic_rdata_i;
                error_d = plic_error_i;
            end
            periph_pkg::SLOT_TIMER: begin
                rdata_d = timer_rdata_i;
                error_d = timer_error_i;
            end
            default: begin
                rdata_d = periph_pkg::ERR_RDATA;
                error_d = 1'b1;
            end
        endcase
        // Writes return zero data
        if (req_write_i) begin
            rdata_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (accept) state_q <= RESP;
                RESP: if (rsp_ready_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Held stable while the response waits
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_rdata_o <= rdata_d;
            rsp_error_o <= error_d;
        end
    end

endmodule

// File: design/periph_pkg.sv
package periph_pkg;

    // ------------------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------------------
    localparam int ADDR_W   = 16;
    localparam int DATA_W   = 32;
    localparam int SLOT_LSB = 12;
    localparam int SLOT_W   = ADDR_W - SLOT_LSB;
    localparam int OFFS_LSB = 2;
    localparam int OFFS_W   = 4;

    localparam logic [DATA_W-1:0] ERR_RDATA = 32'hDEADBEEF;

    // Slots 2 to 15 are unmapped
    typedef enum logic [SLOT_W-1:0] {
        SLOT_PLIC  = 4'd0,
        SLOT_TIMER = 4'd1
    } slot_e;

    // ------------------------------------------------------------------------
    // Timer block
    // ------------------------------------------------------------------------
    localparam int NUM_TIMERS = 2;

    typedef enum logic [OFFS_W-1:0] {
        T0_CTRL    = 4'd0,
        T0_COUNT   = 4'd1,
        T0_COMPARE = 4'd2,
        T0_STATUS  = 4'd3,
        T1_CTRL    = 4'd4,
        T1_COUNT   = 4'd5,
        T1_COMPARE = 4'd6,
        T1_STATUS  = 4'd7
    } timer_reg_e;

    // ------------------------------------------------------------------------
    // Interrupt controller
    // ------------------------------------------------------------------------
    localparam int NUM_SOURCES = 4;
    localparam int ID_W        = 3;
    localparam int PRIO_W      = 3;

    // Id 0 means no interrupt
    localparam int SRC_EXT0   = 1;
    localparam int SRC_EXT1   = 2;
    localparam int SRC_TIMER0 = 3;
    localparam int SRC_TIMER1 = 4;

    typedef logic [ID_W-1:0] id_t;

    typedef enum logic [OFFS_W-1:0] {
        PLIC_PRIO1     = 4'd0,
        PLIC_PRIO2     = 4'd1,
        PLIC_PRIO3     = 4'd2,
        PLIC_PRIO4     = 4'd3,
        PLIC_ENABLE    = 4'd4,
        PLIC_THRESHOLD = 4'd5,
        PLIC_CLAIM     = 4'd6
    } plic_reg_e;

endpackage
